// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_cpu
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
hw/cpu_pkg.sv
hw/bus_sequencer.sv
hw/register_file.sv
hw/execute_unit.sv
hw/cpu_top.sv
test/cpu_properties.sv
test/tb_cpu.sv

// ==== hw/bus_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer #(
	parameter cpu_pkg::addr_t reset_vector = '0
) (
	input  wire                           clk,
	input  wire                           reset,
	input  wire cpu_pkg::byte_t           din,

	input  wire cpu_pkg::fetch_state_t    next_state,
	input  wire                           pc_load,
	input  wire cpu_pkg::addr_t           pc_target,
	input  wire cpu_pkg::addr_t           store_adr,
	input  wire cpu_pkg::byte_t           store_data,

	output cpu_pkg::addr_t                adr,
	output cpu_pkg::byte_t                dout,
	output logic                          ddrv,
	output logic                          read,
	output logic                          write,

	output cpu_pkg::addr_t                pc,
	output cpu_pkg::byte_t                op,
	output cpu_pkg::byte_t                imm_lo,
	output cpu_pkg::byte_t                imm_hi,
	output cpu_pkg::fetch_state_t         state,
	output logic                          commit
);

	// Clock index inside the current machine cycle.
	cpu_pkg::phase_t phase;

	// High for the three cycle kinds that read a byte at PC.
	logic is_fetch;

	// High when the execute unit asks for a store in the next cycle.
	logic store_next;

	assign is_fetch = (state == cpu_pkg::st_ifetch) ||
		(state == cpu_pkg::st_imm_lo) ||
		(state == cpu_pkg::st_imm_hi);

	// The last clock of every machine cycle is where decisions take effect.
	assign commit = (phase == 2'd3);

	assign store_next = commit && (next_state == cpu_pkg::st_store);

	// -------------------------------------------------------------------------
	// Phase counter and cycle kind
	// -------------------------------------------------------------------------

	// The phase counter wraps freely; a machine cycle never stalls.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= '0;
			state <= cpu_pkg::st_ifetch;
		end
		else
		begin
			phase <= phase + 2'd1;
			if (commit)
				state <= next_state;
		end
	end

	// -------------------------------------------------------------------------
	// Bus strobes
	// -------------------------------------------------------------------------

	// A fetch raises read after phase 1 and drops it after phase 3, so read
	// is seen high for two clocks.
	// A store drives the data bus from phase 0 and pulses write for one clock.
	// A jump cycle leaves the strobes alone.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			read  <= 1'b0;
			write <= 1'b0;
			ddrv  <= 1'b0;
		end
		else if (is_fetch)
		begin
			case (phase)
			2'd0: ddrv <= 1'b0;
			2'd1: read <= 1'b1;
			2'd3: read <= 1'b0;
			default: ;
			endcase
		end
		else if (state == cpu_pkg::st_store)
		begin
			case (phase)
			2'd0: ddrv <= 1'b1;
			2'd1: write <= 1'b1;
			2'd2: write <= 1'b0;
			default: ;
			endcase
		end
	end

	// The address follows PC at the start of a fetch.
	// For a store it is set at the commit before, together with the data.
	always_ff @(posedge clk)
	begin
		if (is_fetch && phase == 2'd0)
			adr <= pc;
		else if (store_next)
			adr <= store_adr;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			dout <= '0;
		else if (store_next)
			dout <= store_data;
	end

	// -------------------------------------------------------------------------
	// Program counter
	// -------------------------------------------------------------------------

	// A jump load happens only at commit, so it never meets the phase 1 increment.
	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= reset_vector;
		else if (commit && pc_load)
			pc <= pc_target;
		else if (is_fetch && phase == 2'd1)
			pc <= pc + 16'd1;
	end

	// Fetched bytes are taken in phase 2 while the memory still drives din.
	// Only an opcode fetch replaces the opcode.
	always_ff @(posedge clk)
	begin
		if (phase == 2'd2)
		begin
			case (state)
			cpu_pkg::st_ifetch: op <= din;
			cpu_pkg::st_imm_lo: imm_lo <= din;
			cpu_pkg::st_imm_hi: imm_hi <= din;
			default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// -------------------------------------------------------------------------
	// Basic widths
	// -------------------------------------------------------------------------

	// One byte on the data bus or in a register.
	typedef logic [7:0] byte_t;

	// A bus address or a program counter value.
	typedef logic [15:0] addr_t;

	// The flag nibble, ordered Z, N, H, C from the top bit down.
	typedef logic [3:0] flags_t;

	// Bit positions of the flags inside flags_t.
	localparam int flag_z = 3;
	localparam int flag_n = 2;
	localparam int flag_h = 1;
	localparam int flag_c = 0;

	// Clock index within a machine cycle.
	typedef logic [1:0] phase_t;

	// -------------------------------------------------------------------------
	// Register codes as they appear in the opcode
	// -------------------------------------------------------------------------

	typedef logic [2:0] reg_sel_t;

	localparam reg_sel_t reg_b  = 3'd0;
	localparam reg_sel_t reg_c  = 3'd1;
	localparam reg_sel_t reg_d  = 3'd2;
	localparam reg_sel_t reg_e  = 3'd3;
	localparam reg_sel_t reg_h  = 3'd4;
	localparam reg_sel_t reg_l  = 3'd5;
	localparam reg_sel_t reg_hl = 3'd6;
	localparam reg_sel_t reg_a  = 3'd7;

	// Kind of bus access the current machine cycle performs.
	typedef enum logic [2:0] {
		st_ifetch,
		st_imm_lo,
		st_imm_hi,
		st_store,
		st_jump
	} fetch_state_t;

	// ALU operation, taken straight from opcode bits 5..3.
	typedef enum logic [2:0] {
		alu_add,
		alu_adc,
		alu_sub,
		alu_sbc,
		alu_and,
		alu_xor,
		alu_or,
		alu_cp
	} alu_op_t;

	// Opcode field positions.
	// The group field splits the map into quarters, the other two carry register codes.
	localparam int op_grp_msb = 7;
	localparam int op_grp_lsb = 6;
	localparam int op_dst_msb = 5;
	localparam int op_dst_lsb = 3;
	localparam int op_src_msb = 2;
	localparam int op_src_lsb = 0;

	// The two opcodes that are matched as whole bytes.
	localparam byte_t op_jr = 8'h18;
	localparam byte_t op_jp = 8'hc3;

endpackage

`default_nettype wire

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter cpu_pkg::addr_t reset_vector = '0
) (
	input  wire                   clk,
	input  wire                   reset,
	input  wire cpu_pkg::byte_t   din,

	output wire cpu_pkg::addr_t   adr,
	output wire cpu_pkg::byte_t   dout,
	output wire                   ddrv,
	output wire                   read,
	output wire                   write,
	output wire cpu_pkg::addr_t   pc,
	output wire cpu_pkg::flags_t  f
);

	// -------------------------------------------------------------------------
	// Sequencer to execute unit
	// -------------------------------------------------------------------------

	wire cpu_pkg::byte_t        op;
	wire cpu_pkg::byte_t        imm_lo;
	wire cpu_pkg::byte_t        imm_hi;
	wire cpu_pkg::fetch_state_t state;
	wire                        commit;

	// Execute unit back to the sequencer.
	wire cpu_pkg::fetch_state_t next_state;
	wire                        pc_load;
	wire cpu_pkg::addr_t        pc_target;
	wire cpu_pkg::addr_t        store_adr;
	wire cpu_pkg::byte_t        store_data;

	// Register file traffic.
	wire cpu_pkg::reg_sel_t     src_sel;
	wire cpu_pkg::reg_sel_t     dst_sel;
	wire                        wr_en;
	wire cpu_pkg::byte_t        wr_data;
	wire cpu_pkg::flags_t       flag_wr_mask;
	wire cpu_pkg::flags_t       flag_data;
	wire cpu_pkg::byte_t        src_data;
	wire cpu_pkg::byte_t        a;
	wire cpu_pkg::byte_t        h;
	wire cpu_pkg::byte_t        l;

	// The sequencer owns the bus and PC and starts at the reset vector.
	bus_sequencer #(
		.reset_vector (reset_vector)
	) u_seq (
		.clk        (clk),
		.reset      (reset),
		.din        (din),
		.next_state (next_state),
		.pc_load    (pc_load),
		.pc_target  (pc_target),
		.store_adr  (store_adr),
		.store_data (store_data),
		.adr        (adr),
		.dout       (dout),
		.ddrv       (ddrv),
		.read       (read),
		.write      (write),
		.pc         (pc),
		.op         (op),
		.imm_lo     (imm_lo),
		.imm_hi     (imm_hi),
		.state      (state),
		.commit     (commit)
	);

	register_file u_regs (
		.clk          (clk),
		.reset        (reset),
		.src_sel      (src_sel),
		.dst_sel      (dst_sel),
		.wr_en        (wr_en),
		.wr_data      (wr_data),
		.flag_wr_mask (flag_wr_mask),
		.flag_data    (flag_data),
		.src_data     (src_data),
		.a            (a),
		.h            (h),
		.l            (l),
		.f            (f)
	);

	// Decode and ALU, purely combinational between the two register blocks.
	execute_unit u_exec (
		.op           (op),
		.imm_lo       (imm_lo),
		.imm_hi       (imm_hi),
		.state        (state),
		.commit       (commit),
		.pc           (pc),
		.src_data     (src_data),
		.a            (a),
		.h            (h),
		.l            (l),
		.f            (f),
		.next_state   (next_state),
		.src_sel      (src_sel),
		.dst_sel      (dst_sel),
		.wr_en        (wr_en),
		.wr_data      (wr_data),
		.flag_wr_mask (flag_wr_mask),
		.flag_data    (flag_data),
		.pc_load      (pc_load),
		.pc_target    (pc_target),
		.store_adr    (store_adr),
		.store_data   (store_data)
	);

endmodule

`default_nettype wire

// ==== hw/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  wire cpu_pkg::byte_t         op,
	input  wire cpu_pkg::byte_t         imm_lo,
	input  wire cpu_pkg::byte_t         imm_hi,
	input  wire cpu_pkg::fetch_state_t  state,
	input  wire                         commit,
	input  wire cpu_pkg::addr_t         pc,

	input  wire cpu_pkg::byte_t         src_data,
	input  wire cpu_pkg::byte_t         a,
	input  wire cpu_pkg::byte_t         h,
	input  wire cpu_pkg::byte_t         l,
	input  wire cpu_pkg::flags_t        f,

	output cpu_pkg::fetch_state_t       next_state,
	output cpu_pkg::reg_sel_t           src_sel,
	output cpu_pkg::reg_sel_t           dst_sel,
	output logic                        wr_en,
	output cpu_pkg::byte_t              wr_data,
	output cpu_pkg::flags_t             flag_wr_mask,
	output cpu_pkg::flags_t             flag_data,
	output logic                        pc_load,
	output cpu_pkg::addr_t              pc_target,
	output cpu_pkg::addr_t              store_adr,
	output cpu_pkg::byte_t              store_data
);

	// Opcode fields.
	logic [1:0]        grp;
	cpu_pkg::reg_sel_t fld_dst;
	cpu_pkg::reg_sel_t fld_src;
	cpu_pkg::alu_op_t  alu_op;

	// Instruction classes; anything outside them runs as a NOP.
	logic is_ld_rr;
	logic is_store;
	logic is_ld_imm;
	logic is_alu_r;
	logic is_alu_imm;
	logic is_incdec;
	logic is_jr;
	logic is_jp;
	logic jr_taken;
	logic alu_now;

	// Datapath results.
	cpu_pkg::byte_t  operand;
	logic            carry_in;
	logic [8:0]      wide;
	logic [4:0]      half;
	cpu_pkg::byte_t  alu_res;
	cpu_pkg::flags_t alu_flags;
	cpu_pkg::byte_t  idc_res;
	cpu_pkg::flags_t idc_flags;

	// Decisions before commit qualification.
	logic            do_write;
	logic            do_pc_load;
	cpu_pkg::flags_t do_mask;

	// -------------------------------------------------------------------------
	// Decode
	// -------------------------------------------------------------------------

	assign grp     = op[cpu_pkg::op_grp_msb:cpu_pkg::op_grp_lsb];
	assign fld_dst = op[cpu_pkg::op_dst_msb:cpu_pkg::op_dst_lsb];
	assign fld_src = op[cpu_pkg::op_src_msb:cpu_pkg::op_src_lsb];
	assign alu_op  = cpu_pkg::alu_op_t'(fld_dst);

	// The 01 quarter holds the loads; 0x76 and the (HL) sources fall through as NOPs.
	assign is_ld_rr  = (grp == 2'b01) && (fld_dst != cpu_pkg::reg_hl) &&
		(fld_src != cpu_pkg::reg_hl);
	assign is_store  = (grp == 2'b01) && (fld_dst == cpu_pkg::reg_hl) &&
		(fld_src != cpu_pkg::reg_hl);
	assign is_ld_imm = (grp == 2'b00) && (fld_src == 3'd6) &&
		(fld_dst != cpu_pkg::reg_hl);
	assign is_alu_r   = (grp == 2'b10) && (fld_src != cpu_pkg::reg_hl);
	assign is_alu_imm = (grp == 2'b11) && (fld_src == 3'd6);
	// INC is 00rrr100 and DEC is 00rrr101.
	assign is_incdec = (grp == 2'b00) && (fld_src[2:1] == 2'b10) &&
		(fld_dst != cpu_pkg::reg_hl);
	assign is_jr = (op == cpu_pkg::op_jr) || ((op[7:5] == 3'b001) && (fld_src == 3'd0));
	assign is_jp = (op == cpu_pkg::op_jp);

	// Bit 5 clear means the unconditional form.
	// Bit 4 picks C over Z, and bit 3 is the flag value that takes the branch.
	assign jr_taken = !op[5] ||
		(f[op[4] ? cpu_pkg::flag_c : cpu_pkg::flag_z] == op[3]);

	// INC and DEC name their register in the destination field.
	assign src_sel = (grp == 2'b00) ? fld_dst : fld_src;

	// -------------------------------------------------------------------------
	// ALU
	// -------------------------------------------------------------------------

	always_comb
	begin
		operand = (state == cpu_pkg::st_imm_lo) ? imm_lo : src_data;
		carry_in = f[cpu_pkg::flag_c] &&
			((alu_op == cpu_pkg::alu_adc) || (alu_op == cpu_pkg::alu_sbc));
		wide = '0;
		half = '0;
		alu_res = '0;
		alu_flags = '0;
		case (alu_op)
		cpu_pkg::alu_add, cpu_pkg::alu_adc:
		begin
			wide = {1'b0, a} + {1'b0, operand} + {8'd0, carry_in};
			half = {1'b0, a[3:0]} + {1'b0, operand[3:0]} + {4'd0, carry_in};
			alu_res = wide[7:0];
			alu_flags[cpu_pkg::flag_h] = half[4];
			alu_flags[cpu_pkg::flag_c] = wide[8];
		end
		cpu_pkg::alu_sub, cpu_pkg::alu_sbc, cpu_pkg::alu_cp:
		begin
			// The top bit of each difference is the borrow out of that width.
			wide = {1'b0, a} - {1'b0, operand} - {8'd0, carry_in};
			half = {1'b0, a[3:0]} - {1'b0, operand[3:0]} - {4'd0, carry_in};
			alu_res = wide[7:0];
			alu_flags[cpu_pkg::flag_n] = 1'b1;
			alu_flags[cpu_pkg::flag_h] = half[4];
			alu_flags[cpu_pkg::flag_c] = wide[8];
		end
		cpu_pkg::alu_and:
		begin
			alu_res = a & operand;
			alu_flags[cpu_pkg::flag_h] = 1'b1;
		end
		cpu_pkg::alu_xor: alu_res = a ^ operand;
		cpu_pkg::alu_or: alu_res = a | operand;
		default: alu_res = '0;
		endcase
		alu_flags[cpu_pkg::flag_z] = (alu_res == 8'h00);
	end

	// INC and DEC; the carry bit is masked off when the flags are written.
	always_comb
	begin
		idc_flags = '0;
		if (op[0])
		begin
			idc_res = src_data - 8'd1;
			idc_flags[cpu_pkg::flag_n] = 1'b1;
			idc_flags[cpu_pkg::flag_h] = (src_data[3:0] == 4'h0);
		end
		else
		begin
			idc_res = src_data + 8'd1;
			idc_flags[cpu_pkg::flag_h] = (src_data[3:0] == 4'hf);
		end
		idc_flags[cpu_pkg::flag_z] = (idc_res == 8'h00);
	end

	// -------------------------------------------------------------------------
	// Sequencing and write-back
	// -------------------------------------------------------------------------

	// A register-operand ALU op finishes in its opcode cycle, an immediate one
	// in the cycle that brings in the byte.
	assign alu_now = ((state == cpu_pkg::st_ifetch) && is_alu_r) ||
		((state == cpu_pkg::st_imm_lo) && is_alu_imm);

	always_comb
	begin
		next_state = cpu_pkg::st_ifetch;
		dst_sel = fld_dst;
		wr_data = src_data;
		do_write = 1'b0;
		do_mask = '0;
		flag_data = alu_flags;
		do_pc_load = 1'b0;
		case (state)
		cpu_pkg::st_ifetch:
		begin
			if (is_ld_imm || is_alu_imm || is_jr || is_jp)
				next_state = cpu_pkg::st_imm_lo;
			else if (is_store)
				next_state = cpu_pkg::st_store;
			if (is_ld_rr)
				do_write = 1'b1;
			if (is_incdec)
			begin
				wr_data = idc_res;
				do_write = 1'b1;
				do_mask = '1;
				do_mask[cpu_pkg::flag_c] = 1'b0;
				flag_data = idc_flags;
			end
		end
		cpu_pkg::st_imm_lo:
		begin
			if (is_jp)
				next_state = cpu_pkg::st_imm_hi;
			else if (is_jr && jr_taken)
				next_state = cpu_pkg::st_jump;
			if (is_ld_imm)
			begin
				wr_data = imm_lo;
				do_write = 1'b1;
			end
		end
		cpu_pkg::st_imm_hi: next_state = cpu_pkg::st_jump;
		cpu_pkg::st_jump: do_pc_load = 1'b1;
		default: ;
		endcase

		// CP sets the flags only and keeps A.
		if (alu_now)
		begin
			dst_sel = cpu_pkg::reg_a;
			wr_data = alu_res;
			do_write = (alu_op != cpu_pkg::alu_cp);
			do_mask = '1;
			flag_data = alu_flags;
		end
	end

	// State changes land only on the commit clock.
	assign wr_en = commit && do_write;
	assign flag_wr_mask = commit ? do_mask : '0;
	assign pc_load = commit && do_pc_load;

	// PC already points past the offset byte when JR lands.
	assign pc_target = is_jp ? {imm_hi, imm_lo} : (pc + {{8{imm_lo[7]}}, imm_lo});

	// LD (HL),r takes its data through the normal source path.
	assign store_adr = {h, l};
	assign store_data = src_data;

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire                     clk,
	input  wire                     reset,

	input  wire cpu_pkg::reg_sel_t  src_sel,
	input  wire cpu_pkg::reg_sel_t  dst_sel,
	input  wire                     wr_en,
	input  wire cpu_pkg::byte_t     wr_data,
	input  wire cpu_pkg::flags_t    flag_wr_mask,
	input  wire cpu_pkg::flags_t    flag_data,

	output cpu_pkg::byte_t          src_data,
	output cpu_pkg::byte_t          a,
	output cpu_pkg::byte_t          h,
	output cpu_pkg::byte_t          l,
	output cpu_pkg::flags_t         f
);

	// General registers that are not needed outside this module.
	cpu_pkg::byte_t b;
	cpu_pkg::byte_t c;
	cpu_pkg::byte_t d;
	cpu_pkg::byte_t e;

	// -------------------------------------------------------------------------
	// Register writes
	// -------------------------------------------------------------------------

	// The execute unit qualifies wr_en with commit, so one write per instruction.
	// Writes are held off while reset is asserted.
	// Code 6 names memory at (HL) and has no register behind it.
	always_ff @(posedge clk)
	begin
		if (!reset && wr_en)
		begin
			case (dst_sel)
			cpu_pkg::reg_b: b <= wr_data;
			cpu_pkg::reg_c: c <= wr_data;
			cpu_pkg::reg_d: d <= wr_data;
			cpu_pkg::reg_e: e <= wr_data;
			cpu_pkg::reg_h: h <= wr_data;
			cpu_pkg::reg_l: l <= wr_data;
			cpu_pkg::reg_a: a <= wr_data;
			default: ;
			endcase
		end
	end

	// Each flag bit is replaced only where the mask is set.
	// INC and DEC leave C out of the mask and so keep the old carry.
	always_ff @(posedge clk)
	begin
		if (!reset)
			f <= (f & ~flag_wr_mask) | (flag_data & flag_wr_mask);
	end

	// -------------------------------------------------------------------------
	// Source operand
	// -------------------------------------------------------------------------

	// Indirect reads are not supported, so the (HL) code reads as zero.
	always_comb
	begin
		case (src_sel)
		cpu_pkg::reg_b: src_data = b;
		cpu_pkg::reg_c: src_data = c;
		cpu_pkg::reg_d: src_data = d;
		cpu_pkg::reg_e: src_data = e;
		cpu_pkg::reg_h: src_data = h;
		cpu_pkg::reg_l: src_data = l;
		cpu_pkg::reg_a: src_data = a;
		default: src_data = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== test/cpu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
	input wire        clk,
	input wire        reset,
	input wire        read,
	input wire        write,
	input wire        ddrv,
	input wire [15:0] adr
);

	// ------------------------------------------------------------------------
	// Bus strobe rules
	// ------------------------------------------------------------------------

	// A machine cycle either reads or writes, never both.
	no_read_and_write: assert property (@(posedge clk) disable iff (reset)
		!(read && write))
		else $error("read and write are high together");

	// The data bus is driven whenever a write is strobed.
	write_has_ddrv: assert property (@(posedge clk) disable iff (reset)
		write |-> ddrv)
		else $error("write is high without ddrv");

	// A fetch holds read for two clocks and then drops it.
	read_two_clocks: assert property (@(posedge clk) disable iff (reset)
		$rose(read) |=> read ##1 !read)
		else $error("read pulse is not two clocks long");

	// A store pulses write for a single clock.
	write_one_clock: assert property (@(posedge clk) disable iff (reset)
		$rose(write) |=> !write)
		else $error("write pulse is not one clock long");

	// ------------------------------------------------------------------------
	// Address stability
	// ------------------------------------------------------------------------

	// The address is loaded before the strobe rises, so it must not move under it.
	adr_stable: assert property (@(posedge clk) disable iff (reset)
		(read || write) |-> $stable(adr))
		else $error("adr changes while a strobe is high");

endmodule

bind cpu_top cpu_properties u_props (
	.clk   (clk),
	.reset (reset),
	.read  (read),
	.write (write),
	.ddrv  (ddrv),
	.adr   (adr)
);

`default_nettype wire

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	logic        clk;
	logic        reset;
	logic [7:0]  din;
	wire  [15:0] adr;
	wire  [15:0] pc;
	wire  [7:0]  dout;
	wire         ddrv;
	wire         read;
	wire         write;
	wire  [3:0]  f;

	// Program memory and the expected bus traffic built next to it.
	logic [7:0]  mem [0:65535];
	logic [15:0] exp_rd[$];
	int          rd_tid[$];
	logic [15:0] exp_wa[$];
	logic [7:0]  exp_wd[$];
	logic [3:0]  exp_wf[$];
	bit          exp_wchk[$];
	int          wr_tid[$];

	// Reference machine state. The flags are ordered Z, N, H, C.
	logic [7:0]  m_reg [0:7];
	logic [3:0]  m_f;
	bit          f_known;
	int          ptr;
	int          gen_tid;
	int          planned_mc;
	int          limit;
	int          cycles;
	int          ridx;
	int          widx;
	int          cur_tid;
	bit          read_q;
	int          errs [0:4];
	string       names [0:4];

	cpu_top #(
		.reset_vector (16'h0100)
	) u_dut (
		.clk   (clk),
		.reset (reset),
		.din   (din),
		.adr   (adr),
		.dout  (dout),
		.ddrv  (ddrv),
		.read  (read),
		.write (write),
		.pc    (pc),
		.f     (f)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Program generator and reference model
	// ------------------------------------------------------------------------

	// Every emitted byte that runs is read once, in emission order.
	task emit(input logic [7:0] b);
		mem[ptr[15:0]] = b;
		exp_rd.push_back(ptr[15:0]);
		rd_tid.push_back(gen_tid);
		ptr++;
		planned_mc++;
	endtask

	function logic [2:0] rnd_reg();
		int v;
		v = $urandom % 7;
		return (v == 6) ? 3'd7 : v[2:0];
	endfunction

	task ld_imm(input logic [2:0] r, input logic [7:0] v);
		emit({2'b00, r, 3'b110});
		emit(v);
		m_reg[r] = v;
	endtask

	task ld_rr(input logic [2:0] d, input logic [2:0] s);
		emit({2'b01, d, s});
		m_reg[d] = m_reg[s];
	endtask

	// The store lands at H:L with the register value and the current flags.
	task store(input logic [2:0] r);
		emit({5'b01110, r});
		planned_mc++;
		exp_wa.push_back({m_reg[4], m_reg[5]});
		exp_wd.push_back(m_reg[r]);
		exp_wf.push_back(m_f);
		exp_wchk.push_back(f_known);
		wr_tid.push_back(gen_tid);
	endtask

	task alu(input logic [2:0] op, input bit imm, input logic [2:0] s, input logic [7:0] v);
		int a;
		int b;
		int cin;
		int res;
		int hs;
		if (imm)
		begin
			emit({2'b11, op, 3'b110});
			emit(v);
			b = int'(v);
		end
		else
		begin
			emit({2'b10, op, s});
			b = int'(m_reg[s]);
		end
		a = int'(m_reg[7]);
		cin = (op == 3'd1 || op == 3'd3) ? int'(m_f[0]) : 0;
		case (op)
		3'd0, 3'd1:
		begin
			res = a + b + cin;
			hs = (a & 15) + (b & 15) + cin;
			m_f = {(res & 255) == 0, 1'b0, hs > 15, res > 255};
		end
		3'd2, 3'd3, 3'd7:
		begin
			res = a - b - cin;
			hs = (a & 15) - (b & 15) - cin;
			m_f = {(res & 255) == 0, 1'b1, hs < 0, res < 0};
		end
		3'd4:
		begin
			res = a & b;
			m_f = {res == 0, 3'b010};
		end
		3'd5:
		begin
			res = a ^ b;
			m_f = {res == 0, 3'b000};
		end
		default:
		begin
			res = a | b;
			m_f = {res == 0, 3'b000};
		end
		endcase
		f_known = 1'b1;
		// Compare leaves A alone.
		if (op != 3'd7)
			m_reg[7] = res[7:0];
	endtask

	task incdec(input logic [2:0] r, input bit dec);
		logic [7:0] old;
		int hs;
		old = m_reg[r];
		emit({2'b00, r, 2'b10, dec});
		m_reg[r] = dec ? old - 8'd1 : old + 8'd1;
		// The half flag is the carry or borrow out of bit 3, as for ADD and SUB.
		hs = dec ? int'(old[3:0]) - 1 : int'(old[3:0]) + 1;
		m_f = {m_reg[r] == 8'h00, dec, (hs < 0) || (hs > 15), m_f[0]};
	endtask

	// Condition 0 is unconditional, then NZ, Z, NC and C.
	task jr(input int cc, input int off);
		bit taken;
		case (cc)
		1: taken = !m_f[3];
		2: taken = m_f[3];
		3: taken = !m_f[0];
		4: taken = m_f[0];
		default: taken = 1'b1;
		endcase
		emit((cc == 0) ? 8'h18 : 8'h20 + 8'((cc - 1) * 8));
		emit(off[7:0]);
		if (taken)
		begin
			planned_mc++;
			// Skipped bytes are stores, so a wrong path shows on the bus.
			repeat (off)
			begin
				mem[ptr[15:0]] = 8'h77;
				ptr++;
			end
		end
	endtask

	task jp(input int gap);
		int target;
		target = ptr + 3 + gap;
		emit(8'hc3);
		emit(target[7:0]);
		emit(target[15:8]);
		planned_mc++;
		ptr = target;
	endtask

	task build_program();
		logic [7:0] setup_a [0:3];
		logic [2:0] setup_op [0:3];
		logic [7:0] setup_v [0:3];
		logic [7:0] wrap_v [0:3];
		logic [2:0] r;
		logic [2:0] s;
		setup_a = '{8'h01, 8'h05, 8'h10, 8'h80};
		setup_op = '{3'd6, 3'd2, 3'd7, 3'd0};
		setup_v = '{8'h00, 8'h05, 8'h20, 8'h80};
		wrap_v = '{8'hff, 8'h00, 8'h0f, 8'h10};
		ptr = 16'h0100;

		// Straight-line code from the reset vector.
		gen_tid = 0;
		repeat (4) emit(8'h00);
		ld_imm(0, 8'($urandom));
		ld_rr(1, 0);
		emit(8'h76);
		emit(8'h00);

		// Immediate loads and register copies, each stored through H:L.
		gen_tid = 1;
		for (int i = 0; i < 8; i++)
		begin
			if (i == 6)
				continue;
			ld_imm(4, 8'($urandom));
			ld_imm(5, 8'($urandom));
			ld_imm(i[2:0], 8'($urandom));
			store(i[2:0]);
		end
		for (int i = 0; i < 8; i++)
		begin
			r = rnd_reg();
			s = rnd_reg();
			ld_rr(r, s);
			store(r);
		end

		// Random ALU operations, with the flags defined first.
		gen_tid = 2;
		ld_imm(4, 8'hc0);
		ld_imm(5, 8'($urandom));
		ld_imm(7, 8'h00);
		alu(3'd6, 1'b1, 3'd0, 8'h00);
		for (int i = 0; i < 16; i++)
		begin
			s = ($urandom % 5 == 4) ? 3'd7 : 3'($urandom % 4);
			ld_imm(7, 8'($urandom));
			if (s != 3'd7)
				ld_imm(s, 8'($urandom));
			alu(3'($urandom % 8), 1'($urandom % 2), s, 8'($urandom));
			store(7);
		end

		// INC and DEC with the carry set, then cleared.
		gen_tid = 3;
		ld_imm(7, 8'h90);
		alu(3'd0, 1'b1, 3'd0, 8'h90);
		for (int i = 0; i < 12; i++)
		begin
			if (i == 6)
			begin
				ld_imm(7, 8'h01);
				alu(3'd6, 1'b1, 3'd0, 8'h00);
			end
			r = rnd_reg();
			ld_imm(r, (i < 4) ? wrap_v[i] : 8'($urandom));
			incdec(r, (i < 4) ? i[0] : 1'($urandom % 2));
			store(r);
		end

		// Every JR condition under every Z/C combination, then JP.
		gen_tid = 4;
		for (int k = 0; k < 4; k++)
		begin
			for (int cc = 0; cc < 5; cc++)
			begin
				ld_imm(7, setup_a[k]);
				alu(setup_op[k], 1'b1, 3'd0, setup_v[k]);
				jr(cc, 1 + $urandom % 6);
			end
		end
		jp(2 + $urandom % 28);
		jp(2 + $urandom % 28);

		// The run parks in a JR to itself.
		emit(8'h18);
		emit(8'hfe);
	endtask

	// ------------------------------------------------------------------------
	// Memory model and bus checks
	// ------------------------------------------------------------------------

	// The address is already stable when read rises, so din is ready at the latch.
	always @(posedge clk)
		din <= mem[adr];

	always @(posedge clk)
	begin
		read_q <= read;
		if (!reset && read && !read_q && ridx < exp_rd.size())
		begin
			if (rd_tid[ridx] != cur_tid)
			begin
				report_test(cur_tid);
				cur_tid = rd_tid[ridx];
			end
			assert (adr === exp_rd[ridx])
			else
			begin
				$display("Fail adr: got %h expected %h", adr, exp_rd[ridx]);
				errs[cur_tid]++;
			end
			// PC steps past the byte in the same clock that read rises.
			assert (pc === exp_rd[ridx] + 16'd1)
			else
			begin
				$display("Fail pc: got %h expected %h", pc, exp_rd[ridx] + 16'd1);
				errs[cur_tid]++;
			end
			// A fetch releases the data bus before read is raised.
			assert (ddrv === 1'b0)
			else
			begin
				$display("Fail ddrv: got %h expected %h", ddrv, 1'b0);
				errs[cur_tid]++;
			end
			ridx++;
		end
	end

	always @(posedge clk)
	begin
		if (!reset && write)
		begin
			if (widx >= exp_wa.size())
			begin
				$display("A store at %h was not expected by the program", adr);
				errs[cur_tid]++;
			end
			else
			begin
				assert (adr === exp_wa[widx])
				else
				begin
					$display("Fail adr: got %h expected %h", adr, exp_wa[widx]);
					errs[wr_tid[widx]]++;
				end
				assert (dout === exp_wd[widx])
				else
				begin
					$display("Fail dout: got %h expected %h", dout, exp_wd[widx]);
					errs[wr_tid[widx]]++;
				end
				assert (!exp_wchk[widx] || f === exp_wf[widx])
				else
				begin
					$display("Fail f: got %h expected %h", f, exp_wf[widx]);
					errs[wr_tid[widx]]++;
				end
				widx++;
			end
		end
	end

	task report_test(input int t);
		$display("Test %0d (%s) %s with %0d errors", t, names[t],
			(errs[t] == 0) ? "passed" : "failed", errs[t]);
	endtask

	// ------------------------------------------------------------------------
	// Run control
	// ------------------------------------------------------------------------

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("Timeout after %0d clocks, the program did not complete", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial
	begin
		int total;
		int failed;
		total = 0;
		failed = 0;
		void'($urandom(66057));
		names = '{"straight-line fetch", "loads and stores", "random ALU",
			"INC and DEC", "JR and JP"};
		for (int i = 0; i < 5; i++)
			errs[i] = 0;
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i[15:8] ^ i[7:0]);
		ridx = 0;
		widx = 0;
		cur_tid = 0;
		cycles = 0;
		planned_mc = 0;
		f_known = 1'b0;
		m_f = 4'h0;
		build_program();
		limit = 40 * planned_mc + 16;
		reset = 1'b1;
		din = 8'h00;
		read_q = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		while (ridx < exp_rd.size())
			@(posedge clk);
		repeat (8) @(posedge clk);
		if (widx != exp_wa.size())
		begin
			$display("Only %0d of %0d expected stores were seen", widx, exp_wa.size());
			errs[4]++;
		end
		report_test(cur_tid);
		for (int i = 0; i < 5; i++)
		begin
			total += errs[i];
			if (errs[i] != 0)
				failed++;
		end
		$display("Tests run 5, passed %0d, failed %0d, errors %0d", 5 - failed, failed, total);
		if (total == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
